/* bus_arbiter.f */
hdl/axi_arb_pkg.sv
hdl/grant_fsm.sv
hdl/bus_switch.sv
hdl/bus_arbiter_top.sv
test/clock_gen.sv
test/bus_arbiter_checker.sv
test/tb_bus_arbiter.sv

/* test/tb_bus_arbiter.sv */
module tb_bus_arbiter
    import axi_arb_pkg::*;
();

    localparam int num_masters   = 4;
    localparam int idx_w         = $clog2(num_masters);
    localparam int random_cycles = 2000;
    localparam int min_grants    = 50;

    typedef struct packed {
        logic             owned;
        logic [idx_w-1:0] owner;
    } grant_t;

    logic                   clk;
    logic                   resetn;
    logic [num_masters-1:0] valid;
    axi_req_t               req [num_masters];
    axi_resp_t              resp;
    axi_req_t               slave_req;
    axi_resp_t              master_resp [num_masters];

    grant_t      model       = '0;
    int          grant_count = 0;
    logic [31:0] lfsr;

    clock_gen #(
        .half_period  (20),
        .reset_cycles (2)
    ) i_clock_gen (
        .o_clk    (clk),
        .o_resetn (resetn)
    );

    bus_arbiter_top #(
        .num_masters (num_masters)
    ) i_bus_arbiter_top (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (valid),
        .i_req   (req),
        .i_resp  (resp),
        .o_req   (slave_req),
        .o_resp  (master_resp)
    );

    bind bus_arbiter_top bus_arbiter_checker #(
        .num_masters (num_masters)
    ) i_checker (
        .clk           (clk),
        .resetn        (resetn),
        .i_owned       (owned),
        .i_owner       (owner),
        .i_slave_req   (o_req),
        .i_master_resp (o_resp)
    );

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic random_req(output axi_req_t r);
        logic [$bits(axi_req_t)-1:0] v;
        for (int i = 0; i < $bits(axi_req_t); i++) begin
            take_bit(v[i]);
        end
        r = axi_req_t'(v);
        // keep bursts on legal encodings
        if (r.arburst == 2'b11) begin
            r.arburst = burst_incr;
        end
        if (r.awburst == 2'b11) begin
            r.awburst = burst_wrap;
        end
    endtask

    task automatic random_resp(output axi_resp_t r);
        logic [$bits(axi_resp_t)-1:0] v;
        for (int i = 0; i < $bits(axi_resp_t); i++) begin
            take_bit(v[i]);
        end
        r = axi_resp_t'(v);
    endtask

    // each master flips its request about one cycle in eight
    task automatic random_valid(inout logic [num_masters-1:0] v);
        logic [2:0] draw;
        for (int k = 0; k < num_masters; k++) begin
            for (int i = 0; i < 3; i++) begin
                take_bit(draw[i]);
            end
            if (draw == 3'd0) begin
                v[k] = ~v[k];
            end
        end
    endtask

    // idle takes the lowest asker and the owner keeps it until valid drops
    function automatic grant_t ref_next_grant(
        input grant_t                 cur,
        input logic [num_masters-1:0] v,
        input logic                   rst_n
    );
        grant_t nxt;
        logic   found;
        nxt   = cur;
        found = 1'b0;
        if (!rst_n) begin
            nxt = '0;
        end else if (!cur.owned) begin
            for (int k = 0; k < num_masters; k++) begin
                if (v[k] && !found) begin
                    nxt.owned = 1'b1;
                    nxt.owner = idx_w'(k);
                    found     = 1'b1;
                end
            end
        end else if (!v[cur.owner]) begin
            nxt = '0;
        end
        return nxt;
    endfunction

    function automatic string req_group(input axi_req_t got, input axi_req_t exp);
        if (got.araddr !== exp.araddr || got.arid !== exp.arid
            || got.arlen !== exp.arlen || got.arsize !== exp.arsize
            || got.arburst !== exp.arburst || got.arlock !== exp.arlock
            || got.arcache !== exp.arcache || got.arprot !== exp.arprot
            || got.arvalid !== exp.arvalid) begin
            return "read address";
        end
        if (got.rready !== exp.rready) begin
            return "read data";
        end
        if (got.awid !== exp.awid || got.awaddr !== exp.awaddr
            || got.awlen !== exp.awlen || got.awsize !== exp.awsize
            || got.awburst !== exp.awburst || got.awlock !== exp.awlock
            || got.awcache !== exp.awcache || got.awprot !== exp.awprot
            || got.awvalid !== exp.awvalid) begin
            return "write address";
        end
        if (got.wid !== exp.wid || got.wdata !== exp.wdata || got.wstrb !== exp.wstrb
            || got.wlast !== exp.wlast || got.wvalid !== exp.wvalid) begin
            return "write data";
        end
        return "write response";
    endfunction

    function automatic string resp_group(input axi_resp_t got, input axi_resp_t exp);
        if (got.arready !== exp.arready) begin
            return "read address";
        end
        if (got.rid !== exp.rid || got.rdata !== exp.rdata || got.rresp !== exp.rresp
            || got.rlast !== exp.rlast || got.rvalid !== exp.rvalid) begin
            return "read data";
        end
        if (got.awready !== exp.awready) begin
            return "write address";
        end
        if (got.wready !== exp.wready) begin
            return "write data";
        end
        return "write response";
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic compare_req(input axi_req_t got, input axi_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: o_req %s channel, got %h expected %h",
                                $time, req_group(got, exp), got, exp));
        end
    endtask

    task automatic compare_resp(input axi_resp_t got, input axi_resp_t exp, input int slot);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: o_resp[%0d] %s channel, got %h expected %h",
                                $time, slot, resp_group(got, exp), got, exp));
        end
    endtask

    task automatic drive_cycle(input logic [num_masters-1:0] v);
        axi_req_t  r;
        axi_resp_t s;
        @(posedge clk);
        valid <= v;
        for (int k = 0; k < num_masters; k++) begin
            random_req(r);
            req[k] <= r;
        end
        random_resp(s);
        resp <= s;
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (resetn !== 1'b1 && n < limit) begin
            drive_cycle('1);
            @(negedge clk);
            n++;
        end
        if (resetn !== 1'b1) begin
            abort_run($sformatf("reset was still asserted after %0d cycles", limit));
        end
    endtask

    task automatic wait_for_grant(input int k, input logic [num_masters-1:0] v, input int limit);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < limit && !hit; i++) begin
            drive_cycle(v);
            @(negedge clk);
            hit = model.owned && (model.owner == idx_w'(k));
        end
        if (!hit) begin
            abort_run($sformatf("master %0d was not granted the bus within %0d cycles", k, limit));
        end
    endtask

    task automatic wait_for_idle(input logic [num_masters-1:0] v, input int limit);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < limit && !hit; i++) begin
            drive_cycle(v);
            @(negedge clk);
            hit = !model.owned;
        end
        if (!hit) begin
            abort_run($sformatf("bus was not released within %0d cycles", limit));
        end
    endtask

    always @(posedge clk) begin : model_update
        grant_t nxt;
        nxt = ref_next_grant(model, valid, resetn);
        if (nxt.owned && !model.owned) begin
            grant_count <= grant_count + 1;
        end
        model <= nxt;
    end

    // outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin : compare_outputs
        axi_req_t  exp_req;
        axi_resp_t exp_resp;
        exp_req = '0;
        if (model.owned) begin
            exp_req = req[model.owner];
        end
        compare_req(slave_req, exp_req);
        for (int k = 0; k < num_masters; k++) begin
            exp_resp = '0;
            if (model.owned && model.owner == idx_w'(k)) begin
                exp_resp = resp;
            end
            compare_resp(master_resp[k], exp_resp, k);
        end
        if (i_bus_arbiter_top.i_checker.fail_count != 0) begin
            abort_run("an assertion in the bus checker failed");
        end
    end

    initial begin : stimulus
        logic [num_masters-1:0] v;
        lfsr  = 32'hcb53_8256;
        valid = '0;
        resp  = '0;
        for (int k = 0; k < num_masters; k++) begin
            req[k] = '0;
        end

        // all masters ask during reset and nothing may pass before the release
        wait_reset_release(10);
        wait_for_grant(0, '1, 2);
        wait_for_idle('0, 3);
        repeat (3) drive_cycle('0);

        // several askers from idle
        wait_for_grant(1, 4'b1110, 2);
        repeat (5) drive_cycle(4'b1110);
        wait_for_grant(2, 4'b1100, 3);

        // higher priority arrives late and has to wait
        repeat (6) drive_cycle(4'b1111);
        wait_for_grant(0, 4'b0011, 3);
        repeat (4) drive_cycle(4'b0011);
        wait_for_grant(1, 4'b0010, 3);
        wait_for_idle('0, 3);

        v = '0;
        for (int i = 0; i < random_cycles; i++) begin
            random_valid(v);
            drive_cycle(v);
        end
        wait_for_idle('0, 3);
        if (grant_count < min_grants) begin
            abort_run($sformatf("random run made only %0d grants", grant_count));
        end

        @(negedge clk);
        if (i_bus_arbiter_top.i_checker.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "bus checker reported assertion failures");
        end
    end

endmodule

/* test/bus_arbiter_checker.sv */
module bus_arbiter_checker
    import axi_arb_pkg::*;
#(
    parameter int num_masters = 4,
    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1
) (
    input logic             clk,
    input logic             resetn,
    input logic             i_owned,
    input logic [idx_w-1:0] i_owner,
    input axi_req_t         i_slave_req,
    input axi_resp_t        i_master_resp [num_masters]
);

    int                     fail_count = 0;
    logic [num_masters-1:0] resp_busy;

    always_comb begin
        for (int k = 0; k < num_masters; k++) begin
            resp_busy[k] = (i_master_resp[k] != '0);
        end
    end

    // response goes to one master at most
    resp_one_slot: assert property (@(posedge clk) $onehot0(resp_busy))
    else begin
        $error("more than one master response slot is active");
        fail_count++;
    end

    // free bus means a quiet slave port
    idle_req_zero: assert property (@(posedge clk) !i_owned |-> (i_slave_req == '0))
    else begin
        $error("slave request is not zero while the bus is free");
        fail_count++;
    end

    // a new owner always comes after an idle cycle
    no_direct_handover: assert property (
        @(posedge clk) disable iff (!resetn)
        i_owned |=> (!i_owned || $stable(i_owner))
    )
    else begin
        $error("bus passed from one master to another without an idle cycle");
        fail_count++;
    end

endmodule

/* test/clock_gen.sv */
module clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 2
) (
    output logic o_clk,
    output logic o_resetn
);

    initial begin
        o_clk = 1'b0;
        forever #half_period o_clk = ~o_clk;
    end

    // release lines up with a rising edge
    initial begin
        o_resetn = 1'b0;
        repeat (reset_cycles) @(posedge o_clk);
        o_resetn <= 1'b1;
    end

endmodule

/* hdl/bus_arbiter_top.sv */
module bus_arbiter_top
    import axi_arb_pkg::*;
#(
    // 0 uncached data, 1 uncached instr, 2 dcache, 3 icache
    parameter int num_masters = 4,
    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [num_masters-1:0] i_valid,
    input  axi_req_t               i_req  [num_masters],
    input  axi_resp_t              i_resp,
    output axi_req_t               o_req,
    output axi_resp_t              o_resp [num_masters]
);

    logic             owned;
    logic [idx_w-1:0] owner;

    grant_fsm #(
        .num_masters (num_masters)
    ) i_grant_fsm (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (i_valid),
        .o_owned (owned),
        .o_owner (owner)
    );

    bus_switch #(
        .num_masters (num_masters)
    ) i_bus_switch (
        .i_owned (owned),
        .i_owner (owner),
        .i_req   (i_req),
        .i_resp  (i_resp),
        .o_req   (o_req),
        .o_resp  (o_resp)
    );

endmodule

/* hdl/bus_switch.sv */
module bus_switch
    import axi_arb_pkg::*;
#(
    parameter int num_masters = 4,
    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1
) (
    input  logic             i_owned,
    input  logic [idx_w-1:0] i_owner,
    input  axi_req_t         i_req  [num_masters],
    input  axi_resp_t        i_resp,
    output axi_req_t         o_req,
    output axi_resp_t        o_resp [num_masters]
);

    logic [num_masters-1:0] slot_sel;

    // one-hot owner, empty when the bus is free
    always_comb begin : owner_decode
        slot_sel = '0;
        for (int k = 0; k < num_masters; k++) begin
            if (i_owned && (i_owner == idx_w'(k))) begin
                slot_sel[k] = 1'b1;
            end
        end
    end

    // nothing reaches the slave before a grant
    always_comb begin : req_mux
        o_req = '0;
        for (int k = 0; k < num_masters; k++) begin
            if (slot_sel[k]) begin
                o_req = i_req[k];
            end
        end
    end

    // response goes to the owner only, other slots stay quiet
    for (genvar k = 0; k < num_masters; k++) begin : g_resp
        always_comb begin
            if (slot_sel[k]) begin
                o_resp[k] = i_resp;
            end else begin
                o_resp[k] = '0;
            end
        end
    end

endmodule

/* hdl/grant_fsm.sv */
module grant_fsm
    import axi_arb_pkg::*;
#(
    parameter int num_masters = 4,
    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [num_masters-1:0] i_valid,
    output logic                   o_owned,
    output logic [idx_w-1:0]       o_owner
);

    grant_state_e     state_q;
    grant_state_e     state_d;
    logic [idx_w-1:0] owner_q;
    logic [idx_w-1:0] owner_d;
    logic [idx_w-1:0] pick;
    logic             any_valid;
    logic             owner_valid;

    assign any_valid = |i_valid;

    // lowest asking index wins, so scan from the top down
    always_comb begin : pick_lowest
        pick = '0;
        for (int k = num_masters - 1; k >= 0; k--) begin
            if (i_valid[k]) begin
                pick = idx_w'(k);
            end
        end
    end

    // only the owner's valid matters once the bus is taken
    always_comb begin : owner_watch
        owner_valid = 1'b0;
        for (int k = 0; k < num_masters; k++) begin
            if (owner_q == idx_w'(k)) begin
                owner_valid = i_valid[k];
            end
        end
    end

    always_comb begin : next_state
        state_d = state_q;
        owner_d = owner_q;
        case (state_q)
            st_idle: begin
                if (any_valid) begin
                    state_d = st_owned;
                    owner_d = pick;
                end
            end
            st_owned: begin
                // release takes effect at this edge, next grant one edge later
                if (!owner_valid) begin
                    state_d = st_idle;
                    owner_d = '0;
                end
            end
            default: begin
                state_d = st_idle;
                owner_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= st_idle;
            owner_q <= '0;
        end else begin
            state_q <= state_d;
            owner_q <= owner_d;
        end
    end

    assign o_owned = (state_q == st_owned);
    assign o_owner = owner_q;

endmodule

/* hdl/axi_arb_pkg.sv */
package axi_arb_pkg;

    // axi field widths
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_lock_t;
    typedef logic [3:0]  axi_cache_t;
    typedef logic [2:0]  axi_prot_t;
    typedef logic [1:0]  axi_resp_code_t;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    // master-driven side of all five channels
    typedef struct packed {
        // read address
        axi_addr_t      araddr;
        axi_id_t        arid;
        axi_len_t       arlen;
        axi_size_t      arsize;
        axi_burst_e     arburst;
        axi_lock_t      arlock;
        axi_cache_t     arcache;
        axi_prot_t      arprot;
        logic           arvalid;
        // read data
        logic           rready;
        // write address
        axi_id_t        awid;
        axi_addr_t      awaddr;
        axi_len_t       awlen;
        axi_size_t      awsize;
        axi_burst_e     awburst;
        axi_lock_t      awlock;
        axi_cache_t     awcache;
        axi_prot_t      awprot;
        logic           awvalid;
        // write data
        axi_id_t        wid;
        axi_data_t      wdata;
        axi_strb_t      wstrb;
        logic           wlast;
        logic           wvalid;
        // write response
        logic           bready;
    } axi_req_t;

    // slave-driven side
    typedef struct packed {
        logic           arready;
        axi_id_t        rid;
        axi_data_t      rdata;
        axi_resp_code_t rresp;
        logic           rlast;
        logic           rvalid;
        logic           awready;
        logic           wready;
        axi_id_t        bid;
        axi_resp_code_t bresp;
        logic           bvalid;
    } axi_resp_t;

    // bus ownership
    typedef enum logic {
        st_idle  = 1'b0,
        st_owned = 1'b1
    } grant_state_e;

endpackage
